// File: include/pit_cfg.svh
// Fixed 8253 register map with three 16-bit channels; other values are not supported by the RTL
`ifndef PIT_CFG_SVH
`define PIT_CFG_SVH

// Channels in the timer
`define PIT_NUM_CH 3

// Counter width in bits
`define PIT_CNT_W 16

// Control register address, channels sit at 0 to 2
`define PIT_ADDR_CTRL 3

`endif

// File: rtl/pit_bus_if.sv
// Four-phase slave port; control words with modes 1, 4, 5 or select 3 are dropped, addr 3 reads 0
`include "pit_cfg.svh"

module pit_bus_if import pit_pkg::*; (
  input  logic                                  CLK,
  input  logic                                  LOAD,
  input  logic                                  req,
  input  pit_bus_req_t                          bus_req,
  output logic                                  ack,
  output logic [7:0]                            rdata,
  output pit_ch_cmd_t [`PIT_NUM_CH-1:0]         ch_cmd,
  input  logic        [`PIT_NUM_CH-1:0][7:0]    rd_byte
);

  localparam int         NUM_CH    = `PIT_NUM_CH;
  localparam logic [1:0] ADDR_CTRL = `PIT_ADDR_CTRL;

  pit_ctrl_word_u cw;
  pit_mode_t      mode_v;
  logic           access;
  logic           ctrl_wr;
  logic           is_latch;
  logic           mode_ok;
  logic [7:0]     rd_sel;

  // Access happens at the first edge with req high and ack low
  assign access  = req && !ack;
  assign ctrl_wr = access && bus_req.we && (bus_req.addr == ADDR_CTRL);

  assign cw       = bus_req.wdata;
  assign is_latch = (cw.mode_word.rw == LATCH);
  // Modes 6 and 7 alias 2 and 3 as on the original part
  assign mode_ok  = (cw.mode_word.mode == 3'd0) || cw.mode_word.mode[1];

  always_comb
  begin
    case (cw.mode_word.mode[1:0])
      2'b10:   mode_v = MODE2;
      2'b11:   mode_v = MODE3;
      default: mode_v = MODE0;
    endcase
  end

  // Per-channel commands, valid only on the access cycle
  always_comb
  begin
    ch_cmd = '0;
    for (int i = 0; i < NUM_CH; i++)
    begin
      ch_cmd[i].rw   = cw.mode_word.rw;
      ch_cmd[i].mode = mode_v;
      ch_cmd[i].data = bus_req.wdata;
      if (access && (bus_req.addr == 2'(i)))
      begin
        ch_cmd[i].wr_count = bus_req.we;
        ch_cmd[i].rd_count = !bus_req.we;
      end
      if (ctrl_wr && is_latch && (cw.latch_word.sc == 2'(i)))
        ch_cmd[i].latch = 1'b1;
      if (ctrl_wr && !is_latch && mode_ok && (cw.mode_word.sc == 2'(i)))
        ch_cmd[i].mode_wr = 1'b1;
    end
  end

  // Read byte of the addressed channel, zero for the control address
  always_comb
  begin
    rd_sel = 8'h00;
    for (int i = 0; i < NUM_CH; i++)
    begin
      if (bus_req.addr == 2'(i))
        rd_sel = rd_byte[i];
    end
  end

  always_ff @(posedge CLK or posedge LOAD)
  begin
    if (LOAD)
    begin
      ack   <= 1'b0;
      rdata <= 8'h00;
    end
    else if (access)
    begin
      ack   <= 1'b1;
      rdata <= bus_req.we ? 8'h00 : rd_sel;
    end
    else if (!req)
      ack <= 1'b0;
  end

endmodule

// File: rtl/pit_channel.sv
// One timer channel; a count write before any control word is ignored, BCD is not supported
`include "pit_cfg.svh"

module pit_channel import pit_pkg::*; (
  input  logic        CLK,
  input  logic        LOAD,
  input  pit_ch_cmd_t cmd,
  output logic [7:0]  rd_byte,
  input  logic        cnt_en,
  input  logic        gate,
  output logic        out
);

  localparam int W = `PIT_CNT_W;

  pit_mode_t      mode_q;
  pit_rw_t        rw_q;
  pit_mode_t      cnt_mode;
  logic           wr_msb;
  logic           rd_msb;
  logic           latched;
  logic           load_req;
  logic           last_rd;
  logic           take_latch;
  logic [W-1:0]   count_reg;
  logic [W-1:0]   latch_val;
  logic [W-1:0]   live_count;
  logic [W-1:0]   rd_src;

  // Count is complete after one byte, or after the MSB in two-byte mode
  assign load_req = cmd.wr_count &&
                    ((rw_q == LSB) || (rw_q == MSB) || ((rw_q == LSB_MSB) && wr_msb));

  // Last byte of a read releases a held latch
  assign last_rd = cmd.rd_count && ((rw_q != LSB_MSB) || rd_msb);

  // A second latch command is ignored until the first is read out
  assign take_latch = cmd.latch && !latched;

  // The counter must see the new mode on the edge of its own control write
  assign cnt_mode = cmd.mode_wr ? cmd.mode : mode_q;

  always_ff @(posedge CLK or posedge LOAD)
  begin
    if (LOAD)
    begin
      mode_q  <= MODE0;
      rw_q    <= LATCH;
      wr_msb  <= 1'b0;
      rd_msb  <= 1'b0;
      latched <= 1'b0;
    end
    else if (cmd.mode_wr)
    begin
      mode_q  <= cmd.mode;
      rw_q    <= cmd.rw;
      wr_msb  <= 1'b0;
      rd_msb  <= 1'b0;
      latched <= 1'b0;
    end
    else
    begin
      if (cmd.wr_count && (rw_q == LSB_MSB))
        wr_msb <= !wr_msb;
      if (cmd.rd_count && (rw_q == LSB_MSB))
        rd_msb <= !rd_msb;
      if (take_latch)
        latched <= 1'b1;
      else if (last_rd)
        latched <= 1'b0;
    end
  end

  // Count register and latch snapshot
  always_ff @(posedge CLK)
  begin
    if (take_latch)
      latch_val <= live_count;
    if (cmd.wr_count)
    begin
      case (rw_q)
        LSB:     count_reg <= {8'h00, cmd.data};
        MSB:     count_reg <= {cmd.data, 8'h00};
        LSB_MSB:
        begin
          if (wr_msb)
            count_reg[15:8] <= cmd.data;
          else
            count_reg[7:0] <= cmd.data;
        end
        default: ;
      endcase
    end
  end

  assign rd_src = latched ? latch_val : live_count;

  // Read byte follows the programmed byte order
  always_comb
  begin
    case (rw_q)
      MSB:     rd_byte = rd_src[15:8];
      LSB_MSB: rd_byte = rd_msb ? rd_src[15:8] : rd_src[7:0];
      default: rd_byte = rd_src[7:0];
    endcase
  end

  pit_down_counter i_cnt (
    .CLK        (CLK),
    .LOAD       (LOAD),
    .mode       (cnt_mode),
    .mode_set   (cmd.mode_wr),
    .load_req   (load_req),
    .reload_val (count_reg),
    .cnt_en     (cnt_en),
    .gate       (gate),
    .count      (live_count),
    .out        (out)
  );

endmodule

// File: rtl/pit_down_counter.sv
// Down counter for modes 0, 2 and 3; counts of 0 or 1 in modes 2 and 3 are outside the model
`include "pit_cfg.svh"

module pit_down_counter import pit_pkg::*; (
  input  logic                  CLK,
  input  logic                  LOAD,
  input  pit_mode_t             mode,
  input  logic                  mode_set,
  input  logic                  load_req,
  input  logic [`PIT_CNT_W-1:0] reload_val,
  input  logic                  cnt_en,
  input  logic                  gate,
  output logic [`PIT_CNT_W-1:0] count,
  output logic                  out
);

  localparam int           W   = `PIT_CNT_W;
  localparam logic [W-1:0] ONE = W'(1);
  localparam logic [W-1:0] TWO = W'(2);

  logic         load_pend;
  logic         running;
  logic         gate_q;
  logic         gate_rise;
  logic         rise_pend;
  logic         first_load;
  logic         term;
  logic         reload_now;
  logic         take_new;
  logic [W-1:0] reload_q;
  logic [W-1:0] base;

  // Mode 3 half periods, counted in steps of 2
  function automatic logic [W-1:0] half_hi(input logic [W-1:0] v);
    return v + {{(W-1){1'b0}}, v[0]};
  endfunction

  function automatic logic [W-1:0] half_lo(input logic [W-1:0] v);
    return {v[W-1:1], 1'b0};
  endfunction

  assign rise_pend  = gate_rise || (gate && !gate_q);
  // First count after a control word, or any count in mode 0
  assign first_load = cnt_en && load_pend && (!running || (mode == MODE0));
  assign term       = ((mode == MODE2) && (count == ONE)) ||
                      ((mode == MODE3) && (count == TWO) && !out);
  assign reload_now = cnt_en && running && gate && (mode != MODE0) && (rise_pend || term);
  // Later writes in modes 2 and 3 wait for a reload
  assign take_new   = first_load || (reload_now && load_pend);
  assign base       = take_new ? reload_val : reload_q;

  always_ff @(posedge CLK)
  begin
    if (take_new)
      reload_q <= reload_val;
  end

  always_ff @(posedge CLK or posedge LOAD)
  begin
    if (LOAD)
    begin
      count     <= '0;
      out       <= 1'b0;
      load_pend <= 1'b0;
      running   <= 1'b0;
      gate_q    <= 1'b0;
      gate_rise <= 1'b0;
    end
    else
    begin
      gate_q <= gate;
      // Gate rise is held until a tick consumes it
      if (!gate || cnt_en)
        gate_rise <= 1'b0;
      else if (!gate_q)
        gate_rise <= 1'b1;

      if (mode_set)
      begin
        out       <= (mode != MODE0);
        running   <= 1'b0;
        load_pend <= 1'b0;
      end
      else
      begin
        if (load_req)
          load_pend <= 1'b1;
        else if (take_new)
          load_pend <= 1'b0;

        if (first_load)
        begin
          count   <= (mode == MODE3) ? half_hi(reload_val) : reload_val;
          out     <= (mode != MODE0);
          running <= 1'b1;
        end
        else if (cnt_en && running)
        begin
          case (mode)
            MODE2:
            begin
              if (!gate)
                out <= 1'b1;
              else if (reload_now)
              begin
                count <= base;
                out   <= 1'b1;
              end
              else
              begin
                count <= count - 1'b1;
                if (count == TWO)
                  out <= 1'b0;
              end
            end
            MODE3:
            begin
              if (!gate)
                out <= 1'b1;
              else if (reload_now)
              begin
                count <= half_hi(base);
                out   <= 1'b1;
              end
              else if (count == TWO)
              begin
                count <= half_lo(reload_q);
                out   <= 1'b0;
              end
              else
                count <= count - TWO;
            end
            default:
            begin
              // Mode 0 wraps after terminal count with out held high
              if (gate)
              begin
                count <= count - 1'b1;
                if (count == ONE)
                  out <= 1'b1;
              end
            end
          endcase
        end
      end
    end
  end

endmodule

// File: rtl/pit_pkg.sv
// Types for the 8253-style timer; control word layout follows the original part, BCD bit unused
package pit_pkg;

  // Host request, held stable while req is high
  typedef struct packed {
    logic [1:0] addr;
    logic       we;
    logic [7:0] wdata;
  } pit_bus_req_t;

  // Only the kept counting modes have names
  typedef enum logic [2:0] {
    MODE0 = 3'd0,
    MODE2 = 3'd2,
    MODE3 = 3'd3
  } pit_mode_t;

  // Access mode, LATCH doubles as the counter latch code
  typedef enum logic [1:0] {
    LATCH   = 2'd0,
    LSB     = 2'd1,
    MSB     = 2'd2,
    LSB_MSB = 2'd3
  } pit_rw_t;

  // Mode-setting view of a control word
  typedef struct packed {
    logic [1:0] sc;
    pit_rw_t    rw;
    logic [2:0] mode;
    logic       bcd;
  } pit_mode_word_t;

  // Counter latch view of a control word
  typedef struct packed {
    logic [1:0] sc;
    logic [1:0] latch_code;
    logic [3:0] unused;
  } pit_latch_word_t;

  typedef union packed {
    pit_mode_word_t  mode_word;
    pit_latch_word_t latch_word;
  } pit_ctrl_word_u;

  // One-cycle command to a single channel
  typedef struct packed {
    logic       wr_count;
    logic       rd_count;
    logic       mode_wr;
    logic       latch;
    pit_rw_t    rw;
    pit_mode_t  mode;
    logic [7:0] data;
  } pit_ch_cmd_t;

endpackage

// File: rtl/pit_top.sv
// Three-channel timer top; cnt_en and gate are taken as synchronous to CLK
`include "pit_cfg.svh"

module pit_top import pit_pkg::*; (
  input  logic                   CLK,
  input  logic                   LOAD,
  input  logic                   req,
  input  pit_bus_req_t           bus_req,
  output logic                   ack,
  output logic [7:0]             rdata,
  input  logic [`PIT_NUM_CH-1:0] cnt_en,
  input  logic [`PIT_NUM_CH-1:0] gate,
  output logic [`PIT_NUM_CH-1:0] out
);

  pit_ch_cmd_t [`PIT_NUM_CH-1:0]      ch_cmd;
  logic        [`PIT_NUM_CH-1:0][7:0] rd_byte;

  pit_bus_if i_bus (
    .CLK     (CLK),
    .LOAD    (LOAD),
    .req     (req),
    .bus_req (bus_req),
    .ack     (ack),
    .rdata   (rdata),
    .ch_cmd  (ch_cmd),
    .rd_byte (rd_byte)
  );

  pit_channel i_ch0 (
    .CLK     (CLK),
    .LOAD    (LOAD),
    .cmd     (ch_cmd[0]),
    .rd_byte (rd_byte[0]),
    .cnt_en  (cnt_en[0]),
    .gate    (gate[0]),
    .out     (out[0])
  );

  pit_channel i_ch1 (
    .CLK     (CLK),
    .LOAD    (LOAD),
    .cmd     (ch_cmd[1]),
    .rd_byte (rd_byte[1]),
    .cnt_en  (cnt_en[1]),
    .gate    (gate[1]),
    .out     (out[1])
  );

  pit_channel i_ch2 (
    .CLK     (CLK),
    .LOAD    (LOAD),
    .cmd     (ch_cmd[2]),
    .rd_byte (rd_byte[2]),
    .cnt_en  (cnt_en[2]),
    .gate    (gate[2]),
    .out     (out[2])
  );

endmodule

// File: verif/pit_asserts.sv
// Bound to pit_top; checks the host handshake and out lines, silent while LOAD is high
`include "pit_cfg.svh"

module pit_asserts import pit_pkg::*; (
  input logic                   CLK,
  input logic                   LOAD,
  input logic                   req,
  input pit_bus_req_t           bus_req,
  input logic                   ack,
  input logic [7:0]             rdata,
  input logic [`PIT_NUM_CH-1:0] out
);

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge CLK) disable iff (LOAD) $rose(ack) |-> $past(req))
    else $error("ack rose without a request");

  // Host keeps req up until the access is acknowledged
  req_held: assert property (@(posedge CLK) disable iff (LOAD) req && !ack |=> req || ack)
    else $error("req dropped before ack");

  // Request held through the ack edge, read data held until ack has fallen
  stable_in_ack: assert property (@(posedge CLK) disable iff (LOAD)
    ack |-> $stable(bus_req) ##1 $stable(rdata))
    else $error("bus request or read data changed while ack was high");

  out_known: assert property (@(posedge CLK) disable iff (LOAD) !$isunknown(out))
    else $error("out is unknown");

endmodule

bind pit_top pit_asserts i_asserts (.*);

// File: verif/pit_tb.sv
// Random test of pit_top against a cycle model; mode 3 channels are never read back
`include "pit_cfg.svh"

module pit_tb import pit_pkg::*;;

  logic                   CLK;
  logic                   LOAD;
  logic                   req;
  pit_bus_req_t           bus_req;
  logic                   ack;
  logic [7:0]             rdata;
  logic [`PIT_NUM_CH-1:0] cnt_en;
  logic [`PIT_NUM_CH-1:0] gate;
  logic [`PIT_NUM_CH-1:0] out;

  int          err_cnt = 0;
  int          to_cnt = 0;
  logic [31:0] rs = 32'd37299;
  int          dens = 2;
  int          gate_ctl[3];

  // Model state per channel
  int          m_mode[3];
  logic [1:0]  m_rw[3];
  logic        m_wr_msb[3], m_rd_msb[3], m_latched[3], m_pend[3], m_run[3];
  logic        m_gate_q[3], m_rise[3];
  logic [15:0] m_latch_val[3], m_cnt_reg[3], m_count[3], m_reload[3];
  logic [2:0]  m_out;
  logic        m_ack;
  logic [7:0]  m_rdata;

  pit_top i_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int rnd(input int k);
    rs = xorshift(rs);
    return int'(rs % k);
  endfunction

  function automatic logic [7:0] model_rd_byte(input int c);
    logic [15:0] src;
    src = m_latched[c] ? m_latch_val[c] : m_count[c];
    case (m_rw[c])
      2'd2:    return src[15:8];
      2'd3:    return m_rd_msb[c] ? src[15:8] : src[7:0];
      default: return src[7:0];
    endcase
  endfunction

  // Counter rules for one edge; mode 3 keeps ticks left in the half period
  task automatic counter_step(input int c, input bit mset, input int nmode, input bit lreq);
    bit          tick, g, pend, first, term, rel, take;
    logic [15:0] base;
    tick = cnt_en[c];
    g = gate[c];
    pend = m_rise[c] || (g && !m_gate_q[c]);
    m_rise[c] = tick ? 1'b0 : (pend && g);
    m_gate_q[c] = g;
    if (mset)
    begin
      m_out[c] = (nmode != 0);
      m_run[c] = 0;
      m_pend[c] = 0;
      return;
    end
    first = tick && m_pend[c] && (!m_run[c] || m_mode[c] == 0);
    term = (m_mode[c] == 2 && m_count[c] == 1) ||
           (m_mode[c] == 3 && m_count[c] == 1 && !m_out[c]);
    rel = tick && m_run[c] && g && m_mode[c] != 0 && (pend || term);
    take = first || (rel && m_pend[c]);
    base = take ? m_cnt_reg[c] : m_reload[c];
    if (take)
      m_reload[c] = m_cnt_reg[c];
    if (lreq)
      m_pend[c] = 1;
    else if (take)
      m_pend[c] = 0;
    if (first)
    begin
      m_count[c] = (m_mode[c] == 3) ? (m_cnt_reg[c] + 1) / 2 : m_cnt_reg[c];
      m_out[c] = (m_mode[c] != 0);
      m_run[c] = 1;
    end
    else if (tick && m_run[c])
    begin
      if (m_mode[c] == 0)
      begin
        if (g)
        begin
          if (m_count[c] == 1)
            m_out[c] = 1;
          m_count[c] = m_count[c] - 1;
        end
      end
      else if (!g)
        m_out[c] = 1;
      else if (rel)
      begin
        m_count[c] = (m_mode[c] == 3) ? (base + 1) / 2 : base;
        m_out[c] = 1;
      end
      else if (m_mode[c] == 2)
      begin
        if (m_count[c] == 2)
          m_out[c] = 0;
        m_count[c] = m_count[c] - 1;
      end
      else if (m_count[c] == 1 && m_out[c])
      begin
        m_count[c] = m_reload[c] / 2;
        m_out[c] = 0;
      end
      else
        m_count[c] = m_count[c] - 1;
    end
  endtask

  // Reference model, one step per clock edge
  always @(posedge CLK or posedge LOAD)
  begin : model
    bit          acc, wr, rd, lat, mw, lreq;
    logic [7:0]  d;
    logic [15:0] old_cnt;
    int          nmode;
    if (LOAD)
    begin
      m_ack = 0;
      m_rdata = 0;
      m_out = 0;
      for (int c = 0; c < 3; c++)
      begin
        {m_wr_msb[c], m_rd_msb[c], m_latched[c], m_pend[c], m_run[c]} = '0;
        {m_gate_q[c], m_rise[c], m_rw[c]} = '0;
        m_mode[c] = 0;
        m_count[c] = 0;
        m_cnt_reg[c] = 0;
      end
    end
    else
    begin
      acc = req && !m_ack;
      d = bus_req.wdata;
      if (acc)
        m_rdata = (bus_req.we || bus_req.addr == `PIT_ADDR_CTRL) ? 8'h00
                  : model_rd_byte(bus_req.addr);
      m_ack = acc ? 1'b1 : (req ? m_ack : 1'b0);
      nmode = (d[2:1] == 2'b10) ? 2 : ((d[2:1] == 2'b11) ? 3 : 0);
      for (int c = 0; c < 3; c++)
      begin
        wr = acc && bus_req.we && bus_req.addr == c;
        rd = acc && !bus_req.we && bus_req.addr == c;
        lat = acc && bus_req.we && bus_req.addr == `PIT_ADDR_CTRL && d[5:4] == 0 && d[7:6] == c;
        mw = acc && bus_req.we && bus_req.addr == `PIT_ADDR_CTRL && d[5:4] != 0
             && (d[3:1] == 0 || d[2]) && d[7:6] == c;
        lreq = wr && (m_rw[c] == 1 || m_rw[c] == 2 || (m_rw[c] == 3 && m_wr_msb[c]));
        old_cnt = m_count[c];
        counter_step(c, mw, nmode, lreq);
        if (wr)
        begin
          case (m_rw[c])
            2'd1: m_cnt_reg[c] = {8'h00, d};
            2'd2: m_cnt_reg[c] = {d, 8'h00};
            2'd3:
            begin
              if (m_wr_msb[c])
                m_cnt_reg[c][15:8] = d;
              else
                m_cnt_reg[c][7:0] = d;
            end
            default: ;
          endcase
        end
        if (mw)
        begin
          m_mode[c] = nmode;
          m_rw[c] = d[5:4];
          {m_wr_msb[c], m_rd_msb[c], m_latched[c]} = '0;
        end
        else
        begin
          if (wr && m_rw[c] == 3)
            m_wr_msb[c] = !m_wr_msb[c];
          if (lat && !m_latched[c])
          begin
            m_latched[c] = 1;
            m_latch_val[c] = old_cnt;
          end
          else if (rd && (m_rw[c] != 3 || m_rd_msb[c]))
            m_latched[c] = 0;
          if (rd && m_rw[c] == 3)
            m_rd_msb[c] = !m_rd_msb[c];
        end
      end
    end
  end

  always @(negedge CLK)
  begin
    if (!LOAD)
    begin
      assert (out === m_out && ack === m_ack && rdata === m_rdata)
      else
      begin
        err_cnt++;
        $display("mismatch at %0t: out %b ack %b rdata %h, expected %b %b %h",
                 $time, out, ack, rdata, m_out, m_ack, m_rdata);
      end
    end
  end

  initial
  begin
    CLK = 0;
    forever #4 CLK = !CLK;
  end

  // Tick and gate driver with its own random stream
  initial
  begin : driver
    logic [31:0] ds;
    ds = xorshift(32'd37299);
    forever
    begin
      @(posedge CLK);
      #1;
      for (int c = 0; c < 3; c++)
      begin
        ds = xorshift(ds);
        cnt_en[c] = (ds[1:0] < dens);
        gate[c] = (gate_ctl[c] == 1) || (gate_ctl[c] == 2 && ds[6:4] != 0);
      end
    end
  end

  task automatic bus_access(input bit we, input logic [1:0] addr, input logic [7:0] data);
    int n;
    bus_req = '{addr: addr, we: we, wdata: data};
    req = 1;
    n = 0;
    do
    begin
      @(posedge CLK);
      #1;
      n++;
    end while (!ack && n < 50);
    if (!ack)
    begin
      to_cnt++;
      $display("timeout: no ack for an access to address %0d", addr);
    end
    req = 0;
    n = 0;
    while (ack && n < 50)
    begin
      @(posedge CLK);
      #1;
      n++;
    end
    if (ack)
    begin
      to_cnt++;
      $display("timeout: ack stayed high after req dropped");
    end
  endtask

  task automatic control(input int c, input int rw, input int mode);
    bus_access(1, `PIT_ADDR_CTRL, {2'(c), 2'(rw), 3'(mode), 1'b0});
  endtask

  task automatic write_count(input int c, input int rw, input logic [15:0] n);
    if (rw == 2)
      bus_access(1, 2'(c), n[15:8]);
    else
      bus_access(1, 2'(c), n[7:0]);
    if (rw == 3)
      bus_access(1, 2'(c), n[15:8]);
  endtask

  task automatic read_count(input int c, input int rw);
    bus_access(0, 2'(c), 8'h00);
    if (rw == 3)
      bus_access(0, 2'(c), 8'h00);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  initial
  begin : stimulus
    int c, md, rw;
    LOAD = 1;
    req = 0;
    bus_req = '0;
    cnt_en = '0;
    gate = '0;
    gate_ctl = '{0, 0, 0};
    repeat (8) @(posedge CLK);
    #1;
    LOAD = 0;
    // Reads after reset
    for (int i = 0; i < 3; i++)
      bus_access(0, 2'(i), 8'h00);
    // Byte order in each access mode, counter held by gate low
    for (int r = 1; r < 4; r++)
    begin
      control(0, r, 0);
      write_count(0, r, 16'(xorshift(rs)));
      rs = xorshift(rs);
      idle(8);
      read_count(0, r);
    end
    // Latched read, then live read
    gate_ctl[1] = 1;
    control(1, 3, 0);
    write_count(1, 3, 16'h0120);
    idle(4);
    bus_access(1, `PIT_ADDR_CTRL, {2'd1, 6'd0});
    idle(10);
    read_count(1, 3);
    read_count(1, 3);
    // Mode 0 with a pausing gate
    gate_ctl[1] = 2;
    control(1, 1, 0);
    write_count(1, 1, 16'(2 + rnd(39)));
    idle(100);
    // Modes 2 and 3 with random gate, ticks and rewrites
    for (int r = 0; r < 12; r++)
    begin
      c = rnd(3);
      md = rnd(2) ? 3 : 2;
      rw = rnd(2) ? 1 : 3;
      gate_ctl[c] = (rnd(3) == 0) ? 2 : 1;
      dens = 1 + rnd(4);
      control(c, rw, md);
      write_count(c, rw, 16'(2 + rnd(39)));
      idle(30 + rnd(40));
      if (rnd(2))
        write_count(c, rw, 16'(2 + rnd(39)));
      idle(40);
    end
    // Unsupported modes are ignored, control address reads zero
    foreach (gate_ctl[i])
      gate_ctl[i] = 1;
    for (int m = 1; m < 6; m++)
    begin
      if (m == 1 || m == 4 || m == 5)
      begin
        control(rnd(3), 3, m);
        bus_access(0, `PIT_ADDR_CTRL, 8'h00);
        idle(20);
      end
    end
    $display("checks done: %0d mismatches, %0d timeouts", err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
rtl/pit_pkg.sv
rtl/pit_down_counter.sv
rtl/pit_channel.sv
rtl/pit_bus_if.sv
rtl/pit_top.sv
verif/pit_asserts.sv
verif/pit_tb.sv
